//--- rtl/priv_macros.svh
/*
 * Machine-mode privilege unit constants.
 * Data width, CSR addresses, reset values and exception cause codes.
 */

`ifndef PRIV_MACROS_SVH
`define PRIV_MACROS_SVH

// Width of every CSR and of the PC values passed to and from the pipeline.
`define PRIV_XLEN 32

// ****************************************
// Machine CSR addresses.
// ****************************************
`define CSR_MSTATUS  12'h300
`define CSR_MISA     12'h301
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MBADADDR 12'h343
`define CSR_MINSTRET 12'hB02

// Machine trap vector after reset, 0x100 + 0x40 * PRV_M.
`define MTVEC_RESET 32'h0000_01C0

// RV32I with MXL = 1, the only ISA string this unit reports.
`define MISA_VALUE  32'h4000_0100

// ****************************************
// Synchronous exception codes.
// ****************************************
`define CAUSE_INSN_FAULT 4'd1
`define CAUSE_ILLEGAL    4'd2
`define CAUSE_BREAK      4'd3
`define CAUSE_MAL_L      4'd4
`define CAUSE_FAULT_L    4'd5
`define CAUSE_MAL_S      4'd6
`define CAUSE_FAULT_S    4'd7
`define CAUSE_ECALL_M    4'd11

`endif

//--- rtl/priv_pkg.sv
/*
 * Shared types of the privilege unit.
 * CSR word and address, CSR operation enum and the mcause union.
 */

`include "priv_macros.svh"

package priv_pkg;

  // ****************************************
  // Basic CSR types.
  // ****************************************

  // One CSR data word, also used for PC values.
  typedef logic [`PRIV_XLEN-1:0] word_t;

  // The 12-bit CSR address field of a Zicsr instruction.
  typedef logic [11:0] csr_addr_t;

  // Read-modify-write operation applied to the addressed CSR.
  // The pipeline delivers these as separate strobes and the top
  // folds them into one code.
  typedef enum logic [1:0] {
    CSR_NONE  = 2'b00,
    CSR_SWAP  = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_e;

  // ****************************************
  // mcause layout.
  // ****************************************

  // The cause word is built from its fields when an exception is
  // encoded and handed around as a plain word when it is stored and
  // read back. The top bit marks an interrupt, the low nibble holds
  // the exception code and the bits between are reserved as zero.
  typedef union packed {
    word_t raw;
    struct packed {
      logic        intr;
      logic [26:0] reserved;
      logic [3:0]  code;
    } f;
  } mcause_u;

endpackage

//--- rtl/priv_exception_control.sv
/*
 * Exception controller.
 * Priority encoding of the exception strobes and the pending-trap register.
 */

`timescale 1ns/100ps
`include "priv_macros.svh"

module priv_exception_control (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              fault_insn,
  input  logic              illegal_insn,
  input  logic              breakpoint,
  input  logic              mal_l,
  input  logic              fault_l,
  input  logic              mal_s,
  input  logic              fault_s,
  input  logic              env_m,
  input  logic              pipe_clear,
  input  priv_pkg::word_t   epc,
  input  priv_pkg::word_t   badaddr,
  output logic              trap,
  output priv_pkg::mcause_u cause,
  output priv_pkg::word_t   trap_epc,
  output priv_pkg::word_t   trap_badaddr
);

  logic              any_ex;
  logic              accept;
  logic              pending;
  logic [3:0]        code_next;
  priv_pkg::mcause_u cause_next;

  // ****************************************
  // Priority encoder.
  // ****************************************

  // Any strobe at all in this cycle.
  assign any_ex = fault_insn | illegal_insn | breakpoint | mal_l |
                  fault_l | mal_s | fault_s | env_m;

  // Older pipeline stages win, so an instruction fault beats everything
  // and an ecall only counts when nothing else is reported.
  always_comb begin
    if (fault_insn) begin
      code_next = `CAUSE_INSN_FAULT;
    end else if (illegal_insn) begin
      code_next = `CAUSE_ILLEGAL;
    end else if (breakpoint) begin
      code_next = `CAUSE_BREAK;
    end else if (mal_l) begin
      code_next = `CAUSE_MAL_L;
    end else if (fault_l) begin
      code_next = `CAUSE_FAULT_L;
    end else if (mal_s) begin
      code_next = `CAUSE_MAL_S;
    end else if (fault_s) begin
      code_next = `CAUSE_FAULT_S;
    end else begin
      code_next = `CAUSE_ECALL_M;
    end
  end

  // Synchronous exceptions only, so the interrupt flag stays low.
  always_comb begin
    cause_next.f.intr     = 1'b0;
    cause_next.f.reserved = '0;
    cause_next.f.code     = code_next;
  end

  // ****************************************
  // Pending trap.
  // ****************************************

  // A new exception is only taken when nothing is waiting already.
  assign accept = any_ex & ~pending;

  // The trap fires in the first cycle the pipeline reports drained.
  assign trap = pending & pipe_clear;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (trap) begin
      pending <= 1'b0;
    end else if (accept) begin
      pending <= 1'b1;
    end
  end

  // Cause and addresses of the accepted exception, held until the trap.
  always_ff @(posedge CLK) begin
    if (accept) begin
      cause        <= cause_next;
      trap_epc     <= epc;
      trap_badaddr <= badaddr;
    end
  end

  // While a trap waits, later strobes must leave the held cause alone.
  a_pending_holds: assert property (@(posedge CLK) disable iff (!rst_n)
    (pending && !trap) |=> ($stable(cause.raw) && $stable(trap_epc)));

endmodule

//--- rtl/priv_csr_rfile.sv
/*
 * Machine CSR register file.
 * CSR read mux, read-modify-write, trap updates and the retire counter.
 */

`timescale 1ns/100ps
`include "priv_macros.svh"

module priv_csr_rfile (
  input  logic              CLK,
  input  logic              rst_n,
  input  priv_pkg::csr_op_e op,
  input  priv_pkg::csr_addr_t addr,
  input  priv_pkg::word_t   wdata,
  input  logic              valid_write,
  input  logic              instr_retired,
  input  logic              trap,
  input  priv_pkg::mcause_u cause,
  input  priv_pkg::word_t   trap_epc,
  input  priv_pkg::word_t   trap_badaddr,
  input  logic              mstatus_push,
  input  logic              mstatus_pop,
  output priv_pkg::word_t   rdata,
  output logic              invalid_csr,
  output priv_pkg::word_t   mtvec,
  output priv_pkg::word_t   mepc,
  output logic              mie_bit,
  output logic              mpie_bit
);

  priv_pkg::mcause_u mcause_q;
  priv_pkg::word_t   mbadaddr_q;
  priv_pkg::word_t   mscratch_q;
  priv_pkg::word_t   minstret_q;
  priv_pkg::word_t   mstatus_word;
  priv_pkg::word_t   mie_word;
  priv_pkg::word_t   wr_value;
  logic              msie;
  logic              mtie;
  logic              meie;
  logic              addr_ok;
  logic              read_only;
  logic              op_active;
  logic              do_write;

  // ****************************************
  // Read side.
  // ****************************************

  // Only MIE (bit 3) and MPIE (bit 7) exist in mstatus.
  always_comb begin
    mstatus_word    = '0;
    mstatus_word[3] = mie_bit;
    mstatus_word[7] = mpie_bit;
  end

  // Software, timer and external enables sit at their standard positions.
  always_comb begin
    mie_word     = '0;
    mie_word[3]  = msie;
    mie_word[7]  = mtie;
    mie_word[11] = meie;
  end

  // Current value of the addressed CSR. Unknown addresses read as zero
  // and are flagged through addr_ok.
  always_comb begin
    rdata     = '0;
    addr_ok   = 1'b1;
    read_only = 1'b0;
    case (addr)
      `CSR_MSTATUS:  rdata = mstatus_word;
      `CSR_MIE:      rdata = mie_word;
      `CSR_MTVEC:    rdata = mtvec;
      `CSR_MSCRATCH: rdata = mscratch_q;
      `CSR_MEPC:     rdata = mepc;
      `CSR_MCAUSE:   rdata = mcause_q.raw;
      `CSR_MBADADDR: rdata = mbadaddr_q;
      `CSR_MISA: begin
        rdata     = `MISA_VALUE;
        read_only = 1'b1;
      end
      `CSR_MINSTRET: begin
        rdata     = minstret_q;
        read_only = 1'b1;
      end
      default: addr_ok = 1'b0;
    endcase
  end

  // ****************************************
  // Write side.
  // ****************************************

  assign op_active = (op != priv_pkg::CSR_NONE);

  // A bad address faults on any access; a read-only CSR only on a write.
  assign invalid_csr = op_active & (~addr_ok | (read_only & valid_write));

  assign do_write = op_active & valid_write & ~invalid_csr;

  // New value from the old one and the operand, as csrrw/csrrs/csrrc do.
  always_comb begin
    case (op)
      priv_pkg::CSR_SWAP:  wr_value = wdata;
      priv_pkg::CSR_SET:   wr_value = rdata | wdata;
      priv_pkg::CSR_CLEAR: wr_value = rdata & ~wdata;
      default:             wr_value = rdata;
    endcase
  end

  // Interrupt-enable stack. A trap pushes, mret pops, and both beat
  // a software write in the same cycle.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mie_bit  <= 1'b0;
      mpie_bit <= 1'b0;
    end else if (mstatus_push) begin
      mpie_bit <= mie_bit;
      mie_bit  <= 1'b0;
    end else if (mstatus_pop) begin
      mie_bit  <= mpie_bit;
      mpie_bit <= 1'b1;
    end else if (do_write && (addr == `CSR_MSTATUS)) begin
      mie_bit  <= wr_value[3];
      mpie_bit <= wr_value[7];
    end
  end

  // Registers written only by software.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mtvec      <= `MTVEC_RESET;
      mscratch_q <= '0;
      msie       <= 1'b0;
      mtie       <= 1'b0;
      meie       <= 1'b0;
    end else if (do_write) begin
      case (addr)
        `CSR_MTVEC:    mtvec      <= wr_value;
        `CSR_MSCRATCH: mscratch_q <= wr_value;
        `CSR_MIE: begin
          msie <= wr_value[3];
          mtie <= wr_value[7];
          meie <= wr_value[11];
        end
        default: ;
      endcase
    end
  end

  // Trap state. The hardware update wins over a CSR write.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mepc       <= '0;
      mcause_q   <= '0;
      mbadaddr_q <= '0;
    end else if (trap) begin
      mepc       <= trap_epc;
      mcause_q   <= cause;
      mbadaddr_q <= trap_badaddr;
    end else if (do_write) begin
      case (addr)
        `CSR_MEPC:     mepc         <= wr_value;
        `CSR_MCAUSE:   mcause_q.raw <= wr_value;
        `CSR_MBADADDR: mbadaddr_q   <= wr_value;
        default: ;
      endcase
    end
  end

  // Retired-instruction counter, read-only to software.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      minstret_q <= '0;
    end else if (instr_retired) begin
      minstret_q <= minstret_q + 1'b1;
    end
  end

  // The exception controller and the redirect block must never push and
  // pop the stack in the same cycle.
  a_push_pop_excl: assert property (@(posedge CLK) disable iff (!rst_n)
    !(trap && mstatus_pop));

endmodule

//--- rtl/priv_pipeline_control.sv
/*
 * Pipeline redirect control.
 * Chooses the PC to insert on a trap or return and drives the mstatus stack.
 */

`timescale 1ns/100ps

module priv_pipeline_control (
  input  logic            trap,
  input  logic            ret,
  input  priv_pkg::word_t mtvec,
  input  priv_pkg::word_t mepc,
  output priv_pkg::word_t priv_pc,
  output logic            insert_pc,
  output logic            intr,
  output logic            mstatus_push,
  output logic            mstatus_pop
);

  // ****************************************
  // Redirect priority mux.
  // ****************************************

  // A trap always wins over mret in the same cycle, so the mret is
  // dropped and the pipeline flushes it along with everything else.
  always_comb begin
    priv_pc      = mepc;
    insert_pc    = 1'b0;
    intr         = 1'b0;
    mstatus_push = 1'b0;
    mstatus_pop  = 1'b0;
    if (trap) begin
      // Enter the handler and save the enable bit.
      priv_pc      = mtvec;
      insert_pc    = 1'b1;
      intr         = 1'b1;
      mstatus_push = 1'b1;
    end else if (ret) begin
      // Back to the saved PC and restore the enable bit.
      priv_pc      = mepc;
      insert_pc    = 1'b1;
      mstatus_pop  = 1'b1;
    end
  end

endmodule

//--- rtl/priv_block.sv
/*
 * Top level of the machine-mode privilege unit.
 * Connects exception control, CSR file and redirect control to the pipeline.
 */

`timescale 1ns/100ps

module priv_block (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                fault_insn,
  input  logic                illegal_insn,
  input  logic                breakpoint,
  input  logic                mal_l,
  input  logic                fault_l,
  input  logic                mal_s,
  input  logic                fault_s,
  input  logic                env_m,
  input  priv_pkg::word_t     epc,
  input  priv_pkg::word_t     badaddr,
  input  logic                pipe_clear,
  input  logic                ret,
  input  logic                swap,
  input  logic                set,
  input  logic                clr,
  input  priv_pkg::csr_addr_t addr,
  input  priv_pkg::word_t     wdata,
  input  logic                valid_write,
  input  logic                wb_enable,
  input  logic                instr,
  output priv_pkg::word_t     rdata,
  output logic                invalid_csr,
  output logic                insert_pc,
  output logic                intr,
  output priv_pkg::word_t     priv_pc
);

  priv_pkg::csr_op_e op;
  priv_pkg::mcause_u cause;
  priv_pkg::word_t   trap_epc;
  priv_pkg::word_t   trap_badaddr;
  priv_pkg::word_t   mtvec;
  priv_pkg::word_t   mepc;
  logic              trap;
  logic              instr_retired;
  logic              mie_bit;
  logic              mpie_bit;
  logic              mstatus_push;
  logic              mstatus_pop;

  // Only one strobe is high at a time; the order here is just a tiebreak.
  always_comb begin
    if (swap) begin
      op = priv_pkg::CSR_SWAP;
    end else if (set) begin
      op = priv_pkg::CSR_SET;
    end else if (clr) begin
      op = priv_pkg::CSR_CLEAR;
    end else begin
      op = priv_pkg::CSR_NONE;
    end
  end

  // Writeback of a real instruction, not a bubble.
  assign instr_retired = wb_enable & instr;

  priv_exception_control exc_ctrl0 (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .fault_insn   (fault_insn),
    .illegal_insn (illegal_insn),
    .breakpoint   (breakpoint),
    .mal_l        (mal_l),
    .fault_l      (fault_l),
    .mal_s        (mal_s),
    .fault_s      (fault_s),
    .env_m        (env_m),
    .pipe_clear   (pipe_clear),
    .epc          (epc),
    .badaddr      (badaddr),
    .trap         (trap),
    .cause        (cause),
    .trap_epc     (trap_epc),
    .trap_badaddr (trap_badaddr)
  );

  priv_csr_rfile csr_rfile0 (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .op            (op),
    .addr          (addr),
    .wdata         (wdata),
    .valid_write   (valid_write),
    .instr_retired (instr_retired),
    .trap          (trap),
    .cause         (cause),
    .trap_epc      (trap_epc),
    .trap_badaddr  (trap_badaddr),
    .mstatus_push  (mstatus_push),
    .mstatus_pop   (mstatus_pop),
    .rdata         (rdata),
    .invalid_csr   (invalid_csr),
    .mtvec         (mtvec),
    .mepc          (mepc),
    .mie_bit       (mie_bit),
    .mpie_bit      (mpie_bit)
  );

  priv_pipeline_control pipe_ctrl0 (
    .trap         (trap),
    .ret          (ret),
    .mtvec        (mtvec),
    .mepc         (mepc),
    .priv_pc      (priv_pc),
    .insert_pc    (insert_pc),
    .intr         (intr),
    .mstatus_push (mstatus_push),
    .mstatus_pop  (mstatus_pop)
  );

  // ****************************************
  // Interrupt-enable stack across blocks.
  // ****************************************

  // Taking a trap disables interrupts and saves the old enable.
  a_trap_stacks_mie: assert property (@(posedge CLK) disable iff (!rst_n)
    trap |=> (!mie_bit && (mpie_bit == $past(mie_bit))));

  // An mret that is not overridden by a trap restores the saved enable.
  a_ret_restores_mie: assert property (@(posedge CLK) disable iff (!rst_n)
    (ret && !trap) |=> (mie_bit == $past(mpie_bit)));

endmodule

//--- sim/priv_block_tb.sv
/*
 * Testbench for the machine-mode privilege unit.
 * Clock, reset, test-file reader, step tasks, compare tasks and the watchdog.
 */

`timescale 1ns/100ps
`include "priv_macros.svh"

module priv_block_tb;

  localparam int HALF_PERIOD  = 4;
  // Outputs are sampled 1 ns before the rising edge that follows a drive.
  localparam int SAMPLE_DLY   = 3;
  localparam int CYCLES_PER_LINE = 40;
  localparam int TRAP_WAIT    = 8;

  logic CLK;
  logic rst_n;
  logic fault_insn, illegal_insn, breakpoint, mal_l, fault_l, mal_s, fault_s, env_m;
  priv_pkg::word_t epc;
  priv_pkg::word_t badaddr;
  logic pipe_clear;
  logic ret;
  logic swap, set, clr;
  priv_pkg::csr_addr_t addr;
  priv_pkg::word_t wdata;
  logic valid_write;
  logic wb_enable;
  logic instr;
  priv_pkg::word_t rdata;
  logic invalid_csr;
  logic insert_pc;
  logic intr;
  priv_pkg::word_t priv_pc;

  int value_errors = 0;
  int other_errors = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  priv_block dut0 (.*);

  // ****************************************
  // Clock, cycle counter and watchdog.
  // ****************************************

  initial begin
    CLK = 1'b0;
    forever #(HALF_PERIOD) CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
  end

  // The limit is set once the test file has been counted.
  initial begin
    wait (cycle_limit > 0);
    wait (cycle_count >= cycle_limit);
    $display("Timeout after %0d cycles, the test steps did not finish", cycle_count);
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    $display("TB FAILED");
    $finish;
  end

  // ****************************************
  // Compare tasks.
  // ****************************************

  task automatic check_word(input string name, input priv_pkg::word_t exp,
                            input priv_pkg::word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED t=%0t %0s expected %h actual %h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED t=%0t %0s expected %b actual %b", $time, name, exp, act);
      value_errors++;
    end
  endtask

  // Compared field by field so that a stray reserved bit shows up on its own.
  task automatic check_cause(input priv_pkg::mcause_u exp, input priv_pkg::mcause_u act);
    if (act.f.intr !== exp.f.intr || act.f.reserved !== exp.f.reserved ||
        act.f.code !== exp.f.code) begin
      $display(
        "CHECK FAILED t=%0t mcause expected intr=%b rsv=%h code=%h actual intr=%b rsv=%h code=%h",
        $time, exp.f.intr, exp.f.reserved, exp.f.code,
        act.f.intr, act.f.reserved, act.f.code);
      value_errors++;
    end
  endtask

  // ****************************************
  // Input drivers.
  // ****************************************

  // Every input back to its quiet value. The pipeline counts as drained.
  task automatic drive_idle();
    {fault_insn, illegal_insn, breakpoint, mal_l} = 4'b0;
    {fault_l, mal_s, fault_s, env_m} = 4'b0;
    epc = '0;
    badaddr = '0;
    pipe_clear = 1'b1;
    ret = 1'b0;
    {swap, set, clr} = 3'b0;
    addr = '0;
    wdata = '0;
    valid_write = 1'b0;
    wb_enable = 1'b0;
    instr = 1'b0;
  endtask

  // Mask bit 0 is the instruction fault and bit 7 the ecall, in priority order.
  task automatic drive_strobes(input logic [7:0] mask);
    {env_m, fault_s, mal_s, fault_l, mal_l, breakpoint, illegal_insn, fault_insn} = mask;
  endtask

  // ****************************************
  // Test steps.
  // ****************************************

  // One CSR access; rdata and invalid_csr are checked in the access cycle.
  task automatic do_csr(input logic [63:0] op_name, input priv_pkg::csr_addr_t a,
                        input priv_pkg::word_t wd, input logic wr,
                        input priv_pkg::word_t exp_rd, input logic exp_inv);
    @(negedge CLK);
    drive_idle();
    addr = a;
    wdata = wd;
    valid_write = wr;
    if (op_name == "swap") begin
      swap = 1'b1;
    end else if (op_name == "set") begin
      set = 1'b1;
    end else if (op_name == "clr") begin
      clr = 1'b1;
    end else if (op_name != "rd") begin
      $display("Unknown CSR operation %0s in the test file", op_name);
      other_errors++;
    end
    #(SAMPLE_DLY);
    check_word("rdata", exp_rd, rdata);
    check_bit("invalid_csr", exp_inv, invalid_csr);
  endtask

  // Reads mcause without an operation and checks its fields.
  task automatic do_cause(input logic exp_intr, input logic [3:0] exp_code);
    priv_pkg::mcause_u exp_c;
    priv_pkg::mcause_u act_c;
    @(negedge CLK);
    drive_idle();
    addr = `CSR_MCAUSE;
    #(SAMPLE_DLY);
    exp_c.raw = '0;
    exp_c.f.intr = exp_intr;
    exp_c.f.code = exp_code;
    act_c.raw = rdata;
    check_cause(exp_c, act_c);
  endtask

  // Raises the strobes, keeps the pipeline busy for hold cycles with a late
  // strobe in the first of them, then waits for the single intr pulse.
  task automatic do_exc(input logic [7:0] mask, input priv_pkg::word_t e,
                        input priv_pkg::word_t b, input int hold,
                        input logic [7:0] late_mask, input priv_pkg::word_t exp_pc);
    int waited;
    logic seen;
    @(negedge CLK);
    drive_idle();
    drive_strobes(mask);
    epc = e;
    badaddr = b;
    pipe_clear = (hold == 0);
    #(SAMPLE_DLY);
    check_bit("intr", 1'b0, intr);
    for (int i = 0; i < hold; i++) begin
      @(negedge CLK);
      drive_idle();
      pipe_clear = 1'b0;
      if (i == 0) begin
        drive_strobes(late_mask);
        epc = e + 32'h100;
        badaddr = b + 32'h100;
      end
      #(SAMPLE_DLY);
      check_bit("intr", 1'b0, intr);
    end
    @(negedge CLK);
    drive_idle();
    seen = 1'b0;
    waited = 0;
    while (!seen && waited < TRAP_WAIT) begin
      #(SAMPLE_DLY);
      if (intr) begin
        seen = 1'b1;
      end else begin
        waited++;
        @(negedge CLK);
      end
    end
    if (!seen) begin
      $display("The trap never came: no intr within %0d cycles of pipe_clear", TRAP_WAIT);
      other_errors++;
    end else begin
      check_word("priv_pc", exp_pc, priv_pc);
      check_bit("insert_pc", 1'b1, insert_pc);
      // The pulse lasts exactly one cycle.
      @(negedge CLK);
      drive_idle();
      #(SAMPLE_DLY);
      check_bit("intr", 1'b0, intr);
    end
  endtask

  // An mret redirects to mepc in the same cycle, without intr.
  task automatic do_ret(input priv_pkg::word_t exp_pc);
    @(negedge CLK);
    drive_idle();
    ret = 1'b1;
    #(SAMPLE_DLY);
    check_bit("insert_pc", 1'b1, insert_pc);
    check_bit("intr", 1'b0, intr);
    check_word("priv_pc", exp_pc, priv_pc);
  endtask

  task automatic do_retire(input logic wb, input logic ins, input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge CLK);
      drive_idle();
      wb_enable = wb;
      instr = ins;
    end
  endtask

  // ****************************************
  // Main sequence.
  // ****************************************

  int fd;
  int n;
  int line_count;
  string line;
  logic [63:0] kw;
  logic [63:0] op_name;
  priv_pkg::csr_addr_t t_addr;
  priv_pkg::word_t t_w0, t_w1, t_w2;
  logic t_b0, t_b1;
  logic [7:0] t_m0, t_m1;
  logic [3:0] t_code;
  int t_n;

  initial begin
    drive_idle();
    rst_n = 1'b0;
    line_count = 0;
    // First pass counts the lines so the cycle limit fits the test length.
    fd = $fopen("sim/priv_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test file sim/priv_tests.txt");
      other_errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0) begin
          line_count++;
        end
      end
      $fclose(fd);
      fd = $fopen("sim/priv_tests.txt", "r");
    end
    cycle_limit = (line_count + 1) * CYCLES_PER_LINE;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;
    if (fd != 0) begin
      while ($fscanf(fd, "%s", kw) == 1) begin
        if (kw == "#") begin
          n = $fgets(line, fd);
        end else if (kw == "csr") begin
          n = $fscanf(fd, "%s %h %h %b %h %b", op_name, t_addr, t_w0, t_b0, t_w1, t_b1);
          do_csr(op_name, t_addr, t_w0, t_b0, t_w1, t_b1);
        end else if (kw == "cause") begin
          n = $fscanf(fd, "%b %h", t_b0, t_code);
          do_cause(t_b0, t_code);
        end else if (kw == "exc") begin
          n = $fscanf(fd, "%h %h %h %d %h %h", t_m0, t_w0, t_w1, t_n, t_m1, t_w2);
          do_exc(t_m0, t_w0, t_w1, t_n, t_m1, t_w2);
        end else if (kw == "ret") begin
          n = $fscanf(fd, "%h", t_w0);
          do_ret(t_w0);
        end else if (kw == "retire") begin
          n = $fscanf(fd, "%b %b %d", t_b0, t_b1, t_n);
          do_retire(t_b0, t_b1, t_n);
        end else begin
          $display("Unknown keyword %0s in the test file, line skipped", kw);
          other_errors++;
          n = $fgets(line, fd);
        end
      end
      $fclose(fd);
    end
    @(negedge CLK);
    drive_idle();
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sim/priv_tests.txt
# csr <op rd|swap|set|clr> <addr> <wdata> <wr> <exp_rdata> <exp_inv> | cause <intr> <code>
# exc <mask b0 insn..b7 ecall> <epc> <badaddr> <hold> <late_mask> <exp_pc> | ret <exp_pc> | retire <wb> <instr> <n>
csr rd 340 00000000 0 00000000 0
csr swap 340 a5a5f00f 1 00000000 0
csr set 340 0000ff00 1 a5a5f00f 0
csr clr 340 a000000f 1 a5a5ff0f 0
csr set 340 ffffffff 0 05a5ff00 0
csr rd 340 00000000 0 05a5ff00 0
csr swap 305 00000200 1 000001c0 0
csr set 305 00000004 1 00000200 0
csr clr 305 00000004 1 00000204 0
csr rd 305 00000000 0 00000200 0
csr swap 7c0 12345678 1 00000000 1
csr swap 301 00000000 1 40000100 1
csr rd 301 00000000 0 40000100 0
csr set b02 0000ffff 1 00000000 1
csr rd b02 00000000 0 00000000 0
csr set 300 00000008 1 00000000 0
exc 04 00001000 00000000 0 00 00000200
cause 0 3
csr rd 341 00000000 0 00001000 0
csr rd 300 00000000 0 00000080 0
exc 38 00001010 0000beef 0 00 00000200
cause 0 4
csr rd 343 00000000 0 0000beef 0
csr rd 300 00000000 0 00000000 0
exc 80 00001020 00000000 3 02 00000200
cause 0 b
csr rd 341 00000000 0 00001020 0
csr set 300 00000080 1 00000000 0
ret 00001020
csr rd 300 00000000 0 00000088 0
retire 1 1 5
retire 1 0 3
retire 0 1 2
retire 1 1 2
csr rd b02 00000000 0 00000007 0

//--- flist.f
+incdir+rtl
rtl/priv_pkg.sv
rtl/priv_exception_control.sv
rtl/priv_csr_rfile.sv
rtl/priv_pipeline_control.sv
rtl/priv_block.sv
sim/priv_block_tb.sv
